// File: files.f
src/turf_regmap_pkg.sv
src/turf_bridge_pkg.sv
src/bridge_timer.sv
src/crate_stream_path.sv
src/crate_bridge_fsm.sv
src/turf_id_regs.sv
src/turf_ctrl_top.sv
tests/turf_ctrl_checker.sv
tests/tb_turf_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_turf_ctrl -Mdir "$BUILD_DIR" -o sim_tb -f files.f

"./$BUILD_DIR/sim_tb" | tee "$LOG_FILE"

if grep -q "Some tests failed" "$LOG_FILE"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

// File: tests/tb_turf_ctrl.sv
`timescale 1ns/1ps

module tb_turf_ctrl;

    localparam int TIMEOUT_CYCLES = 40;
    localparam logic [3:0] VER_MAJOR = 4'd1;
    localparam logic [3:0] VER_MINOR = 4'd6;
    localparam logic [7:0] VER_REV = 8'd5;
    localparam logic [15:0] FIRMWARE_DATE = 16'h8C53;
    // Link model answers with the header scrambled by this key
    localparam logic [31:0] RESP_KEY = 32'hA55A6996;
    localparam int APB_LIMIT = 200;
    localparam int MAX_ROWS = 32;

    logic        ps_clk;
    logic        reset = 1'b1;
    logic [27:0] paddr = '0;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [31:0] pwdata = '0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  aurora_up = '0;
    logic [31:0] cmd_tdata;
    logic [1:0]  cmd_tdest;
    logic        cmd_tlast;
    logic        cmd_tvalid;
    logic        cmd_tready = 1'b0;
    logic [31:0] resp_tdata = '0;
    logic [1:0]  resp_tuser = '0;
    logic        resp_tvalid = 1'b0;
    logic        resp_tready;

    // Expected values of the row in flight
    int          row_id = 0;
    logic        row_end = 1'b0;
    logic [31:0] exp_rdata = '0;
    logic        exp_slverr = 1'b0;
    logic [1:0]  exp_beats = '0;
    logic [31:0] exp_hdr = '0;
    logic [31:0] exp_wdata = '0;
    int          rows_seen;
    int          bad_rows;
    int          errors;

    // Stimulus table
    int          num_rows = 0;
    logic        row_write [MAX_ROWS];
    logic [27:0] row_addr [MAX_ROWS];
    logic [31:0] row_wdata [MAX_ROWS];
    logic [3:0]  row_up [MAX_ROWS];
    logic        row_answer [MAX_ROWS];
    logic [31:0] row_rdata [MAX_ROWS];
    logic        row_slverr [MAX_ROWS];
    logic [1:0]  row_beats [MAX_ROWS];

    // Link model state
    logic        answer_en = 1'b0;
    logic        in_cmd = 1'b0;
    logic        seen_last = 1'b0;
    logic        seen_taken = 1'b0;
    logic [31:0] seen_hdr = '0;
    logic [1:0]  seen_dest = '0;
    logic        resp_pend = 1'b0;
    int          resp_delay = 0;

    turf_ctrl_top #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .VER_MAJOR(VER_MAJOR),
        .VER_MINOR(VER_MINOR),
        .VER_REV(VER_REV),
        .FIRMWARE_DATE(FIRMWARE_DATE)
    ) DUT (
        .ps_clk(ps_clk),
        .reset_i(reset),
        .paddr_i(paddr),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr),
        .aurora_up_i(aurora_up),
        .cmd_tdata_o(cmd_tdata),
        .cmd_tdest_o(cmd_tdest),
        .cmd_tlast_o(cmd_tlast),
        .cmd_tvalid_o(cmd_tvalid),
        .cmd_tready_i(cmd_tready),
        .resp_tdata_i(resp_tdata),
        .resp_tuser_i(resp_tuser),
        .resp_tvalid_i(resp_tvalid),
        .resp_tready_o(resp_tready)
    );

    turf_ctrl_checker u_checker (
        .ps_clk(ps_clk),
        .reset_i(reset),
        .paddr_i(paddr),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .prdata_i(prdata),
        .pready_i(pready),
        .pslverr_i(pslverr),
        .cmd_tdata_i(cmd_tdata),
        .cmd_tdest_i(cmd_tdest),
        .cmd_tlast_i(cmd_tlast),
        .cmd_tvalid_i(cmd_tvalid),
        .cmd_tready_i(cmd_tready),
        .resp_tready_i(resp_tready),
        .row_i(row_id),
        .row_end_i(row_end),
        .exp_rdata_i(exp_rdata),
        .exp_slverr_i(exp_slverr),
        .exp_beats_i(exp_beats),
        .exp_hdr_i(exp_hdr),
        .exp_wdata_i(exp_wdata),
        .rows_o(rows_seen),
        .bad_rows_o(bad_rows),
        .errors_o(errors)
    );

    function automatic logic [27:0] local_addr(input logic [26:0] off);
        return {1'b0, off};
    endfunction

    // Bit 27 opens the crate window and 26:25 pick the link
    function automatic logic [27:0] crate_addr(input logic [1:0] link, input logic [24:0] a);
        return {1'b1, link, a};
    endfunction

    function automatic logic [31:0] crate_header(input logic wr, input logic [27:0] addr);
        return {wr, 6'b0, addr[24:0]};
    endfunction

    task automatic add_row(input logic wr, input logic [27:0] addr, input logic [31:0] wdata,
                           input logic [3:0] up, input logic answer,
                           input logic [31:0] rdata, input logic slverr,
                           input logic [1:0] beats);
        row_write[num_rows] = wr;
        row_addr[num_rows] = addr;
        row_wdata[num_rows] = wdata;
        row_up[num_rows] = up;
        row_answer[num_rows] = answer;
        row_rdata[num_rows] = rdata;
        row_slverr[num_rows] = slverr;
        row_beats[num_rows] = beats;
        num_rows++;
    endtask

    //////////////////////////////////////////////////
    // Table of accesses and expected results
    //////////////////////////////////////////////////

    task automatic build_table();
        logic [31:0] datever;
        logic [27:0] a_rd0;
        logic [27:0] a_rd3;
        // Date 8C53 with its top bit dropped and version 1.6.5 below it
        datever = 32'h0C53_1605;
        a_rd0 = crate_addr(2'd0, 25'h0123456);
        a_rd3 = crate_addr(2'd3, 25'h0000040);
        add_row(1'b0, local_addr(27'h0), '0, 4'b1001, 1'b0, "TURF", 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'h4), '0, 4'b1001, 1'b0, datever, 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'h10), '0, 4'b1001, 1'b0, 32'h0, 1'b0, 2'd0);
        // Link 0 and 3 AURORA, link 1 NONE, link 2 type 2
        add_row(1'b1, local_addr(27'h8), 32'h61, 4'b1001, 1'b0, 32'h0, 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'h8), '0, 4'b1001, 1'b0, 32'h61, 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'hC), '0, 4'b1001, 1'b0, 32'h900, 1'b0, 2'd0);
        add_row(1'b0, a_rd0, '0, 4'b1001, 1'b1, crate_header(1'b0, a_rd0) ^ RESP_KEY,
                1'b0, 2'd1);
        add_row(1'b1, crate_addr(2'd3, 25'h1ABCDEF), 32'hDEADBEEF, 4'b1001, 1'b1, 32'h0,
                1'b0, 2'd2);
        add_row(1'b0, a_rd3, '0, 4'b1001, 1'b1, crate_header(1'b0, a_rd3) ^ RESP_KEY,
                1'b0, 2'd1);
        // Rejected before any beat goes out
        add_row(1'b0, crate_addr(2'd1, 25'h0000100), '0, 4'b1001, 1'b1, 32'h0, 1'b1, 2'd0);
        add_row(1'b1, crate_addr(2'd2, 25'h0000200), 32'h12345678, 4'b1001, 1'b1, 32'h0,
                1'b1, 2'd0);
        add_row(1'b0, crate_addr(2'd0, 25'h0000300), '0, 4'b1000, 1'b1, 32'h0, 1'b1, 2'd0);
        add_row(1'b0, local_addr(27'hC), '0, 4'b1000, 1'b0, 32'h870, 1'b0, 2'd0);
        // Silent link runs into the timeout
        add_row(1'b0, crate_addr(2'd3, 25'h1000004), '0, 4'b1001, 1'b0, 32'h0, 1'b1, 2'd1);
        add_row(1'b0, local_addr(27'hC), '0, 4'b1001, 1'b0, 32'h978, 1'b0, 2'd0);
        add_row(1'b1, local_addr(27'hC), 32'hFF, 4'b1001, 1'b0, 32'h0, 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'hC), '0, 4'b0110, 1'b0, 32'h600, 1'b0, 2'd0);
        add_row(1'b1, crate_addr(2'd0, 25'h0000008), 32'hCAFEF00D, 4'b1001, 1'b0, 32'h0,
                1'b1, 2'd2);
        add_row(1'b0, local_addr(27'hC), '0, 4'b1001, 1'b0, 32'h901, 1'b0, 2'd0);
        add_row(1'b1, local_addr(27'hC), 32'h1, 4'b1001, 1'b0, 32'h0, 1'b0, 2'd0);
        add_row(1'b0, local_addr(27'hC), '0, 4'b1001, 1'b0, 32'h900, 1'b0, 2'd0);
    endtask

    // One APB transfer per row with a closing strobe to the checker
    task automatic run_row(input int r);
        int   waited;
        logic got_ready;
        @(posedge ps_clk);
        row_id <= r;
        exp_rdata <= row_rdata[r];
        exp_slverr <= row_slverr[r];
        exp_beats <= row_beats[r];
        exp_hdr <= crate_header(row_write[r], row_addr[r]);
        exp_wdata <= row_wdata[r];
        aurora_up <= row_up[r];
        answer_en <= row_answer[r];
        paddr <= row_addr[r];
        pwrite <= row_write[r];
        pwdata <= row_wdata[r];
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge ps_clk);
        penable <= 1'b1;
        waited = 0;
        got_ready = 1'b0;
        while (!got_ready && waited < APB_LIMIT) begin
            @(negedge ps_clk);
            if (pready) begin
                got_ready = 1'b1;
            end else begin
                waited++;
                @(posedge ps_clk);
            end
        end
        if (!got_ready) begin
            $display("Timeout: row %0d got no pready within %0d cycles", r, APB_LIMIT);
            $display("Some tests failed");
            $finish;
        end else begin
            @(posedge ps_clk);
            psel <= 1'b0;
            penable <= 1'b0;
            row_end <= 1'b1;
            @(posedge ps_clk);
            row_end <= 1'b0;
        end
    endtask

    initial begin
        ps_clk = 1'b0;
        forever #20 ps_clk = ~ps_clk;
    end

    //////////////////////////////////////////////////
    // Link model
    //////////////////////////////////////////////////

    always @(negedge ps_clk) begin
        seen_last = 1'b0;
        seen_taken = resp_tvalid && resp_tready;
        if (cmd_tvalid && cmd_tready) begin
            if (!in_cmd) begin
                seen_hdr = cmd_tdata;
                seen_dest = cmd_tdest;
            end
            in_cmd = !cmd_tlast;
            seen_last = cmd_tlast;
        end
    end

    always @(posedge ps_clk) begin
        cmd_tready <= ($urandom % 3) != 0;
        if (seen_taken) begin
            resp_tvalid <= 1'b0;
        end
        if (seen_last && answer_en) begin
            resp_pend <= 1'b1;
            resp_delay <= $urandom % 8;
            resp_tdata <= seen_hdr ^ RESP_KEY;
            resp_tuser <= seen_dest;
        end else if (resp_pend) begin
            if (resp_delay == 0) begin
                resp_tvalid <= 1'b1;
                resp_pend <= 1'b0;
            end else begin
                resp_delay <= resp_delay - 1;
            end
        end
    end

    initial begin : main
        int unsigned seed_first;
        seed_first = $urandom(32'hbf8e2d37);
        build_table();
        repeat (4) @(posedge ps_clk);
        reset <= 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        @(posedge ps_clk);
        $display("Rows: %0d checked, %0d clean, %0d with errors, %0d errors in total",
                 rows_seen, rows_seen - bad_rows, bad_rows, errors);
        if (errors == 0 && rows_seen == num_rows) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tests/turf_ctrl_checker.sv
`timescale 1ns/1ps

module turf_ctrl_checker (
    input  logic        ps_clk,
    input  logic        reset_i,
    input  logic [27:0] paddr_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] prdata_i,
    input  logic        pready_i,
    input  logic        pslverr_i,
    input  logic [31:0] cmd_tdata_i,
    input  logic [1:0]  cmd_tdest_i,
    input  logic        cmd_tlast_i,
    input  logic        cmd_tvalid_i,
    input  logic        cmd_tready_i,
    input  logic        resp_tready_i,
    input  int          row_i,
    input  logic        row_end_i,
    input  logic [31:0] exp_rdata_i,
    input  logic        exp_slverr_i,
    input  logic [1:0]  exp_beats_i,
    input  logic [31:0] exp_hdr_i,
    input  logic [31:0] exp_wdata_i,
    output int          rows_o,
    output int          bad_rows_o,
    output int          errors_o
);

    int rows = 0;
    int bad_rows = 0;
    int errors = 0;
    int row_errs = 0;
    int beats = 0;
    int completions = 0;
    int access_cycles = 0;

    assign rows_o = rows;
    assign bad_rows_o = bad_rows;
    assign errors_o = errors;

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL at %0t: row %0d %s got 0x%h expected 0x%h", $time, row_i, sig, got, exp);
        errors++;
        row_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: row %0d %s", $time, row_i, msg);
        errors++;
        row_errs++;
    endtask

    //////////////////////////////////////////////////
    // APB completions
    //////////////////////////////////////////////////

    task automatic compare_completion();
        completions++;
        if (!pwrite_i && prdata_i !== exp_rdata_i) begin
            report_mismatch("prdata", prdata_i, exp_rdata_i);
        end
        if (pslverr_i !== exp_slverr_i) begin
            report_mismatch("pslverr", {31'b0, pslverr_i}, {31'b0, exp_slverr_i});
        end
        // Local space is zero-wait and a rejected crate access takes one more cycle
        if (!paddr_i[27] && access_cycles != 1) begin
            report_problem($sformatf("local access took %0d access cycles", access_cycles));
        end
        if (paddr_i[27] && exp_beats_i == 2'd0 && access_cycles != 2) begin
            report_problem($sformatf("rejected crate access took %0d access cycles",
                                     access_cycles));
        end
    endtask

    //////////////////////////////////////////////////
    // Command beats
    //////////////////////////////////////////////////

    task automatic compare_beat();
        logic [31:0] want_data;
        logic        want_last;
        if (beats == 0) begin
            want_data = exp_hdr_i;
            want_last = (exp_beats_i == 2'd1);
        end else begin
            want_data = exp_wdata_i;
            want_last = 1'b1;
        end
        if (beats >= int'(exp_beats_i)) begin
            report_problem("a command beat came out that the access should not send");
        end else begin
            if (cmd_tdata_i !== want_data) begin
                report_mismatch("cmd_tdata", cmd_tdata_i, want_data);
            end
            if (cmd_tdest_i !== paddr_i[26:25]) begin
                report_mismatch("cmd_tdest", {30'b0, cmd_tdest_i}, {30'b0, paddr_i[26:25]});
            end
            if (cmd_tlast_i !== want_last) begin
                report_mismatch("cmd_tlast", {31'b0, cmd_tlast_i}, {31'b0, want_last});
            end
        end
        beats++;
    endtask

    task automatic close_row();
        if (completions != 1) begin
            report_problem($sformatf("saw %0d APB completions instead of one", completions));
        end
        if (beats != int'(exp_beats_i)) begin
            report_problem($sformatf("sent %0d command beats, %0d expected", beats,
                                     exp_beats_i));
        end
        rows++;
        if (row_errs == 0) begin
            $display("row %0d: ok, %0d command beats", row_i, beats);
        end else begin
            bad_rows++;
            $display("row %0d: %0d errors", row_i, row_errs);
        end
        row_errs = 0;
        beats = 0;
        completions = 0;
        access_cycles = 0;
    endtask

    // All DUT outputs are sampled on the falling edge
    always @(negedge ps_clk) begin
        if (reset_i) begin
            if (pready_i || pslverr_i || cmd_tvalid_i || resp_tready_i) begin
                report_problem("an APB or stream output is high during reset");
            end
        end else begin
            if (psel_i && penable_i) begin
                access_cycles++;
            end
            if (psel_i && penable_i && pready_i) begin
                compare_completion();
            end
            // Response side opens only after every command beat is out
            if (resp_tready_i && (exp_beats_i == 2'd0 || beats != int'(exp_beats_i))) begin
                report_problem("resp_tready is high outside the response wait");
            end
            if (cmd_tvalid_i && cmd_tready_i) begin
                compare_beat();
            end
            if (row_end_i) begin
                close_row();
            end
        end
    end

endmodule

// File: src/turf_ctrl_top.sv
`timescale 1ns/1ps

module turf_ctrl_top #(
    parameter int TIMEOUT_CYCLES = 64,
    parameter logic [3:0] VER_MAJOR = 4'd0,
    parameter logic [3:0] VER_MINOR = 4'd6,
    parameter logic [7:0] VER_REV = 8'd5,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000
) (
    input  logic        ps_clk,
    input  logic        reset_i,
    input  logic [turf_regmap_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [turf_regmap_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [turf_regmap_pkg::APB_DATA_W-1:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    input  logic [3:0]  aurora_up_i,
    output logic [31:0] cmd_tdata_o,
    output logic [1:0]  cmd_tdest_o,
    output logic        cmd_tlast_o,
    output logic        cmd_tvalid_o,
    input  logic        cmd_tready_i,
    input  logic [31:0] resp_tdata_i,
    input  logic [1:0]  resp_tuser_i,
    input  logic        resp_tvalid_i,
    output logic        resp_tready_o
);

    logic [7:0]  bridge_type;
    logic        crate_req;
    logic        crate_write;
    logic [26:0] crate_addr;
    logic [31:0] crate_wdata;
    logic        crate_done;
    logic        crate_err;
    logic [31:0] crate_rdata;
    logic [3:0]  link_timeout;
    logic [3:0]  link_invalid;

    // Bridge sequencing
    logic load;
    logic send;
    logic resp_wait;
    logic sent;
    logic resp_hit;
    logic expired;

    turf_id_regs #(
        .VER_MAJOR(VER_MAJOR),
        .VER_MINOR(VER_MINOR),
        .VER_REV(VER_REV),
        .FIRMWARE_DATE(FIRMWARE_DATE)
    ) u_id_regs (
        .ps_clk(ps_clk),
        .reset_i(reset_i),
        .paddr_i(paddr_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .aurora_up_i(aurora_up_i),
        .bridge_type_o(bridge_type),
        .crate_req_o(crate_req),
        .crate_write_o(crate_write),
        .crate_addr_o(crate_addr),
        .crate_wdata_o(crate_wdata),
        .crate_done_i(crate_done),
        .crate_err_i(crate_err),
        .crate_rdata_i(crate_rdata),
        .link_timeout_i(link_timeout),
        .link_invalid_i(link_invalid)
    );

    crate_bridge_fsm u_bridge_fsm (
        .ps_clk(ps_clk),
        .reset_i(reset_i),
        .crate_req_i(crate_req),
        .crate_write_i(crate_write),
        .crate_addr_i(crate_addr),
        .bridge_type_i(bridge_type),
        .aurora_up_i(aurora_up_i),
        .crate_done_o(crate_done),
        .crate_err_o(crate_err),
        .link_timeout_o(link_timeout),
        .link_invalid_o(link_invalid),
        .load_o(load),
        .send_o(send),
        .wait_o(resp_wait),
        .sent_i(sent),
        .resp_hit_i(resp_hit),
        .expired_i(expired)
    );

    bridge_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timer (
        .ps_clk(ps_clk),
        .reset_i(reset_i),
        .run_i(resp_wait),
        .expired_o(expired)
    );

    crate_stream_path u_stream (
        .ps_clk(ps_clk),
        .reset_i(reset_i),
        .load_i(load),
        .send_i(send),
        .wait_i(resp_wait),
        .write_i(crate_write),
        .addr_i(crate_addr),
        .wdata_i(crate_wdata),
        .cmd_tdata_o(cmd_tdata_o),
        .cmd_tdest_o(cmd_tdest_o),
        .cmd_tlast_o(cmd_tlast_o),
        .cmd_tvalid_o(cmd_tvalid_o),
        .cmd_tready_i(cmd_tready_i),
        .resp_tdata_i(resp_tdata_i),
        .resp_tuser_i(resp_tuser_i),
        .resp_tvalid_i(resp_tvalid_i),
        .resp_tready_o(resp_tready_o),
        .sent_o(sent),
        .resp_hit_o(resp_hit),
        .rdata_o(crate_rdata)
    );

endmodule

// File: src/turf_id_regs.sv
`timescale 1ns/1ps

module turf_id_regs #(
    parameter logic [3:0] VER_MAJOR = 4'd0,
    parameter logic [3:0] VER_MINOR = 4'd6,
    parameter logic [7:0] VER_REV = 8'd5,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000
) (
    input  logic        ps_clk,
    input  logic        reset_i,
    input  logic [turf_regmap_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [turf_regmap_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [turf_regmap_pkg::APB_DATA_W-1:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    input  logic [3:0]  aurora_up_i,
    output logic [7:0]  bridge_type_o,
    output logic        crate_req_o,
    output logic        crate_write_o,
    output logic [26:0] crate_addr_o,
    output logic [31:0] crate_wdata_o,
    input  logic        crate_done_i,
    input  logic        crate_err_i,
    input  logic [31:0] crate_rdata_i,
    input  logic [3:0]  link_timeout_i,
    input  logic [3:0]  link_invalid_i
);

    localparam logic [31:0] DATEVER_WORD =
        {1'b0, FIRMWARE_DATE[14:0], VER_MAJOR, VER_MINOR, VER_REV};

    logic        is_crate;
    logic [26:0] offset;
    logic        local_wr;
    logic [7:0]  bridge_type_q;
    logic [3:0]  timeout_q;
    logic [3:0]  invalid_q;
    logic [31:0] status_w;
    logic [31:0] rdata;

    assign is_crate = paddr_i[turf_regmap_pkg::CRATE_SEL_BIT];
    assign offset = paddr_i[turf_regmap_pkg::CRATE_SEL_BIT-1:0];
    assign local_wr = psel_i && penable_i && pwrite_i && !is_crate;

    // Crate request fires in the APB setup phase
    assign crate_req_o = psel_i && !penable_i && is_crate;
    assign crate_write_o = pwrite_i;
    assign crate_addr_o = offset;
    assign crate_wdata_o = pwdata_i;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            bridge_type_q <= '0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            if (local_wr && offset == turf_regmap_pkg::REG_BRIDGE_TYPE) begin
                bridge_type_q <= pwdata_i[7:0];
            end
            // New events win over a write-one-to-clear in the same cycle
            if (local_wr && offset == turf_regmap_pkg::REG_STATUS) begin
                timeout_q <= (timeout_q & ~pwdata_i[turf_regmap_pkg::STAT_TIMEOUT_LO +: 4])
                             | link_timeout_i;
                invalid_q <= (invalid_q & ~pwdata_i[turf_regmap_pkg::STAT_INVALID_LO +: 4])
                             | link_invalid_i;
            end else begin
                timeout_q <= timeout_q | link_timeout_i;
                invalid_q <= invalid_q | link_invalid_i;
            end
        end
    end

    assign bridge_type_o = bridge_type_q;

    always_comb begin
        status_w = '0;
        status_w[turf_regmap_pkg::STAT_TIMEOUT_LO +: 4] = timeout_q;
        status_w[turf_regmap_pkg::STAT_INVALID_LO +: 4] = invalid_q;
        status_w[turf_regmap_pkg::STAT_UP_LO +: 4] = aurora_up_i;
    end

    //////////////////////////////////////////////////
    // Read mux and APB response
    //////////////////////////////////////////////////

    always_comb begin
        rdata = '0;
        if (is_crate) begin
            rdata = crate_err_i ? '0 : crate_rdata_i;
        end else begin
            case (offset)
                turf_regmap_pkg::REG_IDENT:       rdata = turf_regmap_pkg::IDENT_WORD;
                turf_regmap_pkg::REG_DATEVER:     rdata = DATEVER_WORD;
                turf_regmap_pkg::REG_BRIDGE_TYPE: rdata = {24'h0, bridge_type_q};
                turf_regmap_pkg::REG_STATUS:      rdata = status_w;
                default:                          rdata = '0;
            endcase
        end
    end

    assign prdata_o = rdata;
    // Local space is zero-wait while crate space waits on the bridge
    assign pready_o = psel_i && penable_i && (!is_crate || crate_done_i);
    assign pslverr_o = psel_i && penable_i && is_crate && crate_done_i && crate_err_i;

    // Bridge may only finish while the master waits in a crate access
    a_done_in_access: assert property (@(posedge ps_clk) disable iff (reset_i)
        crate_done_i |-> psel_i && penable_i && is_crate);

endmodule

// File: src/crate_bridge_fsm.sv
`timescale 1ns/1ps

module crate_bridge_fsm (
    input  logic        ps_clk,
    input  logic        reset_i,
    input  logic        crate_req_i,
    input  logic        crate_write_i,
    input  logic [26:0] crate_addr_i,
    input  logic [7:0]  bridge_type_i,
    input  logic [3:0]  aurora_up_i,
    output logic        crate_done_o,
    output logic        crate_err_o,
    output logic [3:0]  link_timeout_o,
    output logic [3:0]  link_invalid_o,
    output logic        load_o,
    output logic        send_o,
    output logic        wait_o,
    input  logic        sent_i,
    input  logic        resp_hit_i,
    input  logic        expired_i
);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_CHECK = 3'd1;
    localparam logic [2:0] S_SEND = 3'd2;
    localparam logic [2:0] S_WAIT = 3'd3;
    localparam logic [2:0] S_FINISH = 3'd4;

    logic [2:0] state_q;
    logic       err_q;
    logic [turf_bridge_pkg::LINK_W-1:0] link_q;
    logic [1:0] link_type;
    logic       link_ok;
    logic [turf_bridge_pkg::NUM_LINKS-1:0] link_sel;

    // Link index is latched with the request
    always_ff @(posedge ps_clk) begin
        if (crate_req_i && state_q == S_IDLE) begin
            link_q <= crate_addr_i[turf_regmap_pkg::LINK_SEL_LO +: turf_bridge_pkg::LINK_W];
        end
    end

    assign link_type = bridge_type_i[{link_q, 1'b0} +: 2];
    assign link_sel = turf_bridge_pkg::NUM_LINKS'(1) << link_q;

    always_comb begin
        case (link_type)
            turf_bridge_pkg::BRIDGE_NONE:   link_ok = 1'b0;
            turf_bridge_pkg::BRIDGE_AURORA: link_ok = aurora_up_i[link_q];
            // Types 2 and 3 have no bridge behind them
            default:                        link_ok = 1'b0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            err_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (crate_req_i) state_q <= S_CHECK;
                S_CHECK: begin
                    err_q <= !link_ok;
                    state_q <= link_ok ? S_SEND : S_FINISH;
                end
                S_SEND: if (sent_i) state_q <= S_WAIT;
                S_WAIT: begin
                    if (resp_hit_i || expired_i) begin
                        err_q <= !resp_hit_i;
                        state_q <= S_FINISH;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign load_o = (state_q == S_CHECK) && link_ok;
    assign send_o = (state_q == S_SEND);
    assign wait_o = (state_q == S_WAIT);
    assign crate_done_o = (state_q == S_FINISH);
    assign crate_err_o = err_q;

    assign link_invalid_o = (state_q == S_CHECK && !link_ok) ? link_sel : '0;
    assign link_timeout_o = (wait_o && !resp_hit_i && expired_i) ? link_sel : '0;

    // No command beat may still go out once the access has finished
    a_done_not_send: assert property (@(posedge ps_clk) disable iff (reset_i)
        !(crate_done_o && sent_i));

    // APB holds the request fields until the bridge finishes
    a_req_stable: assert property (@(posedge ps_clk) disable iff (reset_i)
        (state_q != S_IDLE) |-> $stable({crate_write_i, crate_addr_i}));

endmodule

// File: src/crate_stream_path.sv
`timescale 1ns/1ps

module crate_stream_path (
    input  logic        ps_clk,
    input  logic        reset_i,
    input  logic        load_i,
    input  logic        send_i,
    input  logic        wait_i,
    input  logic        write_i,
    input  logic [26:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] cmd_tdata_o,
    output logic [1:0]  cmd_tdest_o,
    output logic        cmd_tlast_o,
    output logic        cmd_tvalid_o,
    input  logic        cmd_tready_i,
    input  logic [31:0] resp_tdata_i,
    input  logic [1:0]  resp_tuser_i,
    input  logic        resp_tvalid_i,
    output logic        resp_tready_o,
    output logic        sent_o,
    output logic        resp_hit_o,
    output logic [31:0] rdata_o
);

    turf_bridge_pkg::crate_word_u hdr_w;

    logic        tvalid_q;
    logic        data_pend_q;
    logic [31:0] wdata_q;
    logic        beat_fire;

    always_comb begin
        hdr_w.hdr.is_write = write_i;
        hdr_w.hdr.rsvd = '0;
        hdr_w.hdr.addr = addr_i[turf_bridge_pkg::CRATE_ADDR_W-1:0];
    end

    assign cmd_tvalid_o = tvalid_q && send_i;
    assign beat_fire = cmd_tvalid_o && cmd_tready_i;
    assign sent_o = beat_fire && cmd_tlast_o;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            tvalid_q <= 1'b0;
            data_pend_q <= 1'b0;
        end else if (load_i) begin
            tvalid_q <= 1'b1;
            data_pend_q <= write_i;
        end else if (beat_fire) begin
            // Header of a write is followed by its data beat
            data_pend_q <= 1'b0;
            tvalid_q <= data_pend_q;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (load_i) begin
            cmd_tdata_o <= hdr_w.raw;
            cmd_tdest_o <= addr_i[turf_bridge_pkg::CRATE_ADDR_W +: turf_bridge_pkg::LINK_W];
            cmd_tlast_o <= !write_i;
            wdata_q <= wdata_i;
        end else if (beat_fire && data_pend_q) begin
            cmd_tdata_o <= wdata_q;
            cmd_tlast_o <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    // Beats for other links are taken and dropped
    assign resp_tready_o = wait_i;
    assign resp_hit_o = wait_i && resp_tvalid_i && (resp_tuser_i == cmd_tdest_o);

    always_ff @(posedge ps_clk) begin
        if (resp_hit_o) begin
            rdata_o <= resp_tdata_i;
        end
    end

    a_cmd_hold: assert property (@(posedge ps_clk) disable iff (reset_i)
        cmd_tvalid_o && !cmd_tready_i |=>
            cmd_tvalid_o && $stable(cmd_tdata_o) && $stable(cmd_tdest_o));

endmodule

// File: src/bridge_timer.sv
`timescale 1ns/1ps

module bridge_timer #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic ps_clk,
    input  logic reset_i,
    input  logic run_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // Counts response wait cycles, restarts whenever run drops
    always_ff @(posedge ps_clk) begin
        if (reset_i || !run_i) begin
            count_q <= '0;
            expired_o <= 1'b0;
        end else if (!expired_o) begin
            count_q <= count_q + 1'b1;
            if (count_q == CNT_W'(TIMEOUT_CYCLES - 1)) begin
                expired_o <= 1'b1;
            end
        end
    end

endmodule

// File: src/turf_bridge_pkg.sv
package turf_bridge_pkg;

    localparam int NUM_LINKS = 4;
    localparam int LINK_W = 2;

    // Per-link bridge type field
    localparam logic [1:0] BRIDGE_NONE = 2'd0;
    localparam logic [1:0] BRIDGE_AURORA = 2'd1;

    // Address space behind one TURFIO link
    localparam int CRATE_ADDR_W = 25;

    //////////////////////////////////////////////////
    // Crate stream word
    //////////////////////////////////////////////////

    // First beat of a command is a header, later beats are plain data
    typedef union packed {
        struct packed {
            logic is_write;
            logic [5:0] rsvd;
            logic [CRATE_ADDR_W-1:0] addr;
        } hdr;
        logic [31:0] raw;
    } crate_word_u;

endpackage

// File: src/turf_regmap_pkg.sv
package turf_regmap_pkg;

    //////////////////////////////////////////////////
    // APB window
    //////////////////////////////////////////////////

    localparam int APB_ADDR_W = 28;
    localparam int APB_DATA_W = 32;

    // Bit 27 set means the access goes out over a crate link
    localparam int CRATE_SEL_BIT = 27;
    // Link index sits at 26:25 inside the crate window
    localparam int LINK_SEL_LO = 25;

    //////////////////////////////////////////////////
    // Local registers
    //////////////////////////////////////////////////

    localparam logic [CRATE_SEL_BIT-1:0] REG_IDENT = 27'h0;
    localparam logic [CRATE_SEL_BIT-1:0] REG_DATEVER = 27'h4;
    localparam logic [CRATE_SEL_BIT-1:0] REG_BRIDGE_TYPE = 27'h8;
    localparam logic [CRATE_SEL_BIT-1:0] REG_STATUS = 27'hC;

    localparam logic [APB_DATA_W-1:0] IDENT_WORD = "TURF";

    // Status word layout, one nibble per field
    localparam int STAT_TIMEOUT_LO = 0;
    localparam int STAT_INVALID_LO = 4;
    localparam int STAT_UP_LO = 8;

endpackage
